/* include/misc_defines.svh */
`ifndef MISC_DEFINES_SVH
`define MISC_DEFINES_SVH

// word addresses on the register bus.
`define ADR_CTRL        4'h0
`define ADR_SWRESET     4'h1
`define ADR_RGB1        4'h2
`define ADR_RGB2        4'h3
`define ADR_RGB3        4'h4
`define ADR_RGB4        4'h5
`define ADR_CFG_VALUE   4'h6
`define ADR_CFG_REG     4'h7

// reset values.
`define SWRESET_INIT    5'b11111   // all subsystems held in reset.
`define CFG_REG_INIT    5'd7

// configuration port model.
`define CFG_READ_CYCLES 6          // cycles that busy stays high per read.

// answer table, every other register number reads zero.
`define CFG_REG_IDCODE  5'd12
`define CFG_REG_STAT    5'd7
`define CFG_IDCODE      32'h0424_A093
`define CFG_STAT        32'h0000_0E3C

`endif

/* hdl/misc_pkg.sv */
`default_nettype none

package misc_pkg;

   // configuration register number.
   typedef logic [0:4] cfg_reg_t;

   typedef struct packed {
      logic [0:3][0:3] en;       // enable mask per rgb led, led1 first.
      logic [16:29]    unused;
      logic            red;
      logic            green;
   } ctrl_word_t;

   typedef struct packed {
      logic [0:7]  unused;
      logic [0:23] colour;     // red, green, blue bytes.
   } rgb_word_t;

   typedef struct packed {
      logic        busy;
      logic [1:26] unused;
      cfg_reg_t    reg_num;
   } cfg_word_t;

   // sw reset word, bits 29 to 31 read back as ones.
   typedef struct packed {
      logic [0:23] unused;
      logic [0:4]  vec;
      logic [0:2]  ones;
   } swr_word_t;

   // one bus word, decoded by address.
   typedef union packed {
      logic [0:31] raw;
      ctrl_word_t  ctrl;
      rgb_word_t   rgb;
      cfg_word_t   cfg;
      swr_word_t   swr;
   } misc_word_u;

endpackage

`default_nettype wire

/* hdl/mmio_bus_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface mmio_bus_if;
   logic [0:3]  adr;
   logic        cs;
   logic [0:3]  sel;    // byte lanes, only sel[3] qualifies a write.
   logic        we;
   logic [0:31] d;
   logic [0:31] q;      // combinational from adr.

   modport master (
      output adr,
      output cs,
      output sel,
      output we,
      output d,
      input  q
   );

   modport slave (
      input  adr,
      input  cs,
      input  sel,
      input  we,
      input  d,
      output q
   );
endinterface

`default_nettype wire

/* hdl/icap_reader.sv */
`default_nettype none
`timescale 1ns/1ps
`include "misc_defines.svh"

module icap_reader (
   input  logic              clk,
   input  logic              reset,
   input  misc_pkg::cfg_reg_t reg_num,
   input  logic              trigger,
   output logic              busy,
   output logic [0:31]       value
);
   import misc_pkg::*;

   localparam int CNT_W = $clog2(`CFG_READ_CYCLES + 1);

   logic [CNT_W-1:0] count;
   cfg_reg_t         req_reg;   // register number held for the running read.
   logic             done;

   // fixed answers in place of the real configuration port.
   function automatic logic [0:31] answer(input cfg_reg_t r);
      case (r)
         `CFG_REG_IDCODE: answer = `CFG_IDCODE;
         `CFG_REG_STAT:   answer = `CFG_STAT;
         default:         answer = 32'h0;
      endcase
   endfunction

   assign done = busy && (count == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         busy  <= 1'b0;
         count <= '0;
         value <= '0;
      end else if (busy) begin
         if (done) begin
            busy  <= 1'b0;
            value <= answer(req_reg);
         end else
            count <= count - 1'b1;
      end else if (trigger) begin
         busy  <= 1'b1;
         count <= CNT_W'(`CFG_READ_CYCLES - 1);
      end
   end

   always_ff @(posedge clk) begin
      if (trigger && !busy)
         req_reg <= reg_num;   // triggers during a read are dropped.
   end

   a_value_stable: assert property (
      @(posedge clk) disable iff (reset)
      !done |=> $stable(value)
   );

   a_busy_length: assert property (
      @(posedge clk) disable iff (reset)
      $rose(busy) |-> busy [* `CFG_READ_CYCLES] ##1 !busy
   );

endmodule

`default_nettype wire

/* hdl/misc_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "misc_defines.svh"

module misc_regs (
   input  logic        clk,
   input  logic        reset,
   mmio_bus_if.slave   bus,
   input  logic [1:3]  drive_activity,
   output logic        led_red,
   output logic        led_green,
   output logic [0:4]  sw_reset,
   output logic [0:23] led1_rgb,
   output logic [0:23] led2_rgb,
   output logic [0:23] led3_rgb,
   output logic [0:23] led4_rgb
);
   import misc_pkg::*;

   misc_word_u      wr;
   misc_word_u      rd;
   logic            wr_en;
   logic            is_rgb;
   logic [1:0]      rgb_idx;
   logic [0:3][0:3] rgb_en;
   logic [0:23]     rgb_value [0:3];
   logic [0:3][0:23] led_rgb;
   logic [0:23]     status_rgb;
   cfg_reg_t        cfg_reg;
   logic            trigger;
   logic            cfg_busy;
   logic [0:31]     cfg_value;

   assign wr.raw  = bus.d;
   assign wr_en   = bus.cs && bus.we && bus.sel[3];
   assign is_rgb  = (bus.adr >= `ADR_RGB1) && (bus.adr <= `ADR_RGB4);
   assign rgb_idx = 2'(bus.adr - `ADR_RGB1);

   always_ff @(posedge clk) begin
      if (reset) begin
         led_red   <= 1'b0;
         led_green <= 1'b0;
         rgb_en    <= '0;
         sw_reset  <= `SWRESET_INIT;
         cfg_reg   <= `CFG_REG_INIT;
         trigger   <= 1'b0;
      end else begin
         trigger <= 1'b0;
         if (wr_en) begin
            case (bus.adr)
               `ADR_CTRL: begin
                  led_red   <= wr.ctrl.red;
                  led_green <= wr.ctrl.green;
                  rgb_en    <= wr.ctrl.en;
               end
               `ADR_SWRESET: sw_reset <= wr.swr.vec;
               `ADR_CFG_REG: begin
                  cfg_reg <= wr.cfg.reg_num; // updated even while a read runs.
                  trigger <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && is_rgb)
         rgb_value[rgb_idx] <= wr.rgb.colour;
   end

   // read data.
   always_comb begin
      rd.raw = '0;
      case (bus.adr)
         `ADR_CTRL: begin
            rd.ctrl.en    = rgb_en;
            rd.ctrl.red   = led_red;
            rd.ctrl.green = led_green;
         end
         `ADR_SWRESET: begin
            rd.swr.vec  = sw_reset;
            rd.swr.ones = 3'b111;
         end
         `ADR_RGB1, `ADR_RGB2, `ADR_RGB3, `ADR_RGB4: rd.rgb.colour = rgb_value[rgb_idx];
         `ADR_CFG_VALUE: rd.raw = cfg_value;
         `ADR_CFG_REG: begin
            rd.cfg.busy    = cfg_busy;
            rd.cfg.reg_num = cfg_reg;
         end
         default: ;
      endcase
   end

   assign bus.q = rd.raw;

   // leds 1 and 2 fall back to the status colour, 3 and 4 to black.
   assign status_rgb = {{8{led_red}}, {8{led_green}}, 8'h00};

   for (genvar i = 0; i < 4; i++) begin : g_led
      logic [0:23] dflt;
      assign dflt       = (i < 2) ? status_rgb : 24'h000000;
      assign led_rgb[i] = |(rgb_en[i] & {1'b1, drive_activity}) ? rgb_value[i] : dflt;
   end

   assign led1_rgb = led_rgb[0];
   assign led2_rgb = led_rgb[1];
   assign led3_rgb = led_rgb[2];
   assign led4_rgb = led_rgb[3];

   icap_reader u_icap (
      .clk     (clk),
      .reset   (reset),
      .reg_num (cfg_reg),
      .trigger (trigger),
      .busy    (cfg_busy),
      .value   (cfg_value)
   );

   a_trigger_after_write: assert property (
      @(posedge clk) disable iff (reset)
      trigger |-> $past(wr_en && (bus.adr == `ADR_CFG_REG))
   );

endmodule

`default_nettype wire

/* hdl/misc_top.sv */
`default_nettype none
`timescale 1ns/1ps

module misc_top (
   input  logic        clk,
   input  logic        reset,
   input  logic [0:3]  adr,
   input  logic        cs,
   input  logic [0:3]  sel,
   input  logic        we,
   input  logic [0:31] d,
   output logic [0:31] q,
   input  logic [1:3]  drive_activity,
   output logic        led_red,
   output logic        led_green,
   output logic [0:4]  sw_reset,
   output logic [0:23] led1_rgb,
   output logic [0:23] led2_rgb,
   output logic [0:23] led3_rgb,
   output logic [0:23] led4_rgb
);

   mmio_bus_if bus ();

   // bus pins into the interface.
   assign bus.adr = adr;
   assign bus.cs  = cs;
   assign bus.sel = sel;
   assign bus.we  = we;
   assign bus.d   = d;
   assign q       = bus.q;

   misc_regs u_regs (
      .clk            (clk),
      .reset          (reset),
      .bus            (bus.slave),
      .drive_activity (drive_activity),
      .led_red        (led_red),
      .led_green      (led_green),
      .sw_reset       (sw_reset),
      .led1_rgb       (led1_rgb),
      .led2_rgb       (led2_rgb),
      .led3_rgb       (led3_rgb),
      .led4_rgb       (led4_rgb)
   );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset is released on a falling edge, like every other input.
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

/* bench/misc_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "misc_defines.svh"

module misc_tb;
   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_ACT, OP_WAIT} op_t;

   typedef struct {
      string            name;
      op_t              op;
      logic [3:0]       adr;
      logic [31:0]      data;
      logic [3:0]       sel;
      logic [2:0]       act;
      logic [31:0]      exp_q;
      logic [3:0][23:0] exp_led;
      logic [1:0]       exp_stat;
      logic [4:0]       exp_sw;
   } step_t;

   wire              clk;
   wire              reset;
   logic [3:0]       adr;
   logic             cs;
   logic [3:0]       sel;
   logic             we;
   logic [31:0]      d;
   logic [2:0]       drive_activity;
   wire  [31:0]      q;
   wire              led_red;
   wire              led_green;
   wire  [4:0]       sw_reset;
   wire  [3:0][23:0] led_rgb;

   step_t       steps [$];
   bit          table_done = 1'b0;
   int          n_checks = 0;
   int          n_err = 0;
   logic [31:0] lcg_state = 32'd44;

   // reference model state in numeric bit order.
   logic [23:0] m_col [4];
   logic [3:0]  m_en [4] = '{4'h0, 4'h0, 4'h0, 4'h0};
   logic        m_red = 1'b0;
   logic        m_green = 1'b0;
   logic        m_busy = 1'b0;
   logic [4:0]  m_sw = 5'b11111;
   logic [4:0]  m_cfg = 5'd7;
   logic [2:0]  m_act = 3'd0;
   logic [31:0] m_val = 32'h0;

   clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) u_clk (.clk(clk), .reset(reset));

   misc_top dut (
      .clk (clk), .reset (reset), .adr (adr), .cs (cs), .sel (sel), .we (we), .d (d),
      .q (q), .drive_activity (drive_activity), .led_red (led_red),
      .led_green (led_green), .sw_reset (sw_reset), .led1_rgb (led_rgb[0]),
      .led2_rgb (led_rgb[1]), .led3_rgb (led_rgb[2]), .led4_rgb (led_rgb[3])
   );

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] read_value(input logic [3:0] a);
      case (a)
         `ADR_CTRL:      return {m_en[0], m_en[1], m_en[2], m_en[3], 14'h0, m_red, m_green};
         `ADR_SWRESET:   return {24'h0, m_sw, 3'b111};
         `ADR_RGB1, `ADR_RGB2, `ADR_RGB3, `ADR_RGB4:
            return {8'h0, m_col[2'(a - `ADR_RGB1)]};
         `ADR_CFG_VALUE: return m_val;
         `ADR_CFG_REG:   return {m_busy, 26'h0, m_cfg};
         default:        return 32'h0;
      endcase
   endfunction

   function automatic logic [23:0] led_colour(input logic [1:0] i);
      if ((m_en[i] & {1'b1, m_act}) != 4'h0)
         return m_col[i];
      if (i < 2'd2)
         return {{8{m_red}}, {8{m_green}}, 8'h00}; // status colour.
      return 24'h0;
   endfunction

   task automatic track_write(input logic [3:0] a, input logic [31:0] data);
      case (a)
         `ADR_CTRL: begin
            {m_en[0], m_en[1], m_en[2], m_en[3]} = data[31:16];
            m_red   = data[1];
            m_green = data[0];
         end
         `ADR_SWRESET: m_sw = data[7:3];
         `ADR_RGB1, `ADR_RGB2, `ADR_RGB3, `ADR_RGB4: m_col[2'(a - `ADR_RGB1)] = data[23:0];
         `ADR_CFG_REG: m_cfg = data[4:0];
         default: ;
      endcase
   endtask

   task automatic add_step(input string name, input op_t op, input logic [3:0] a,
                           input logic [31:0] data, input logic [3:0] s_sel);
      step_t s;
      if (op == OP_WRITE && s_sel[0])
         track_write(a, data); // only the lane that maps to sel[3] writes.
      if (op == OP_ACT)
         m_act = data[2:0];
      s.name     = name;
      s.op       = op;
      s.adr      = a;
      s.data     = data;
      s.sel      = s_sel;
      s.act      = m_act;
      s.exp_q    = read_value(a);
      s.exp_sw   = m_sw;
      s.exp_stat = {m_red, m_green};
      for (int i = 0; i < 4; i++)
         s.exp_led[i] = led_colour(2'(i));
      steps.push_back(s);
   endtask

   task automatic build_table();
      logic [31:0] r;
      for (int a = 0; a < 16; a++)
         if (a < 2 || a > 5)
            add_step("reset", OP_READ, 4'(a), 32'h0, 4'h0);
      for (int a = 2; a <= 5; a++) begin
         add_step("registers", OP_WRITE, 4'(a), lcg_next(), 4'hF);
         add_step("registers", OP_READ, 4'(a), 32'h0, 4'h0);
      end
      add_step("registers", OP_WRITE, `ADR_CTRL, lcg_next(), 4'hF);
      add_step("registers", OP_READ, `ADR_CTRL, 32'h0, 4'h0);
      add_step("registers", OP_WRITE, `ADR_RGB2, lcg_next(), 4'hE);
      add_step("registers", OP_WRITE, `ADR_CTRL, lcg_next(), 4'h6);
      add_step("registers", OP_READ, `ADR_RGB2, 32'h0, 4'h0);
      // every led sees every mask against all activity values.
      for (int m = 0; m < 16; m++) begin
         r = {4'(m), 4'(m + 5), 4'(m + 10), 4'(m + 15), 14'h0, 2'(m)};
         add_step("colour_select", OP_WRITE, `ADR_CTRL, r, 4'hF);
         for (int a = 0; a < 8; a++)
            add_step("colour_select", OP_ACT, `ADR_CTRL, 32'(a), 4'h0);
      end
      for (int s = 1; s < 4; s++)
         add_step("status_leds", OP_WRITE, `ADR_CTRL, 32'(s), 4'hF);
      add_step("sw_reset", OP_WRITE, `ADR_SWRESET, 32'h0000_00B0, 4'hF);
      add_step("sw_reset", OP_READ, `ADR_SWRESET, 32'h0, 4'h0);
      add_step("sw_reset", OP_WRITE, `ADR_SWRESET, 32'hFFFF_FF4D, 4'hF);
      add_step("sw_reset", OP_READ, `ADR_SWRESET, 32'h0, 4'h0);
      for (int k = 0; k < 2; k++) begin
         add_step("config_read", OP_WRITE, `ADR_CFG_REG, (k == 0) ? 32'd12 : 32'd3, 4'hF);
         m_busy = 1'b1;
         add_step("config_read", OP_READ, `ADR_CFG_REG, 32'h0, 4'h0);
         m_busy = 1'b0;
         m_val  = (k == 0) ? `CFG_IDCODE : 32'h0;
         add_step("config_read", OP_WAIT, `ADR_CFG_REG, 32'h0, 4'h0);
         add_step("config_read", OP_READ, `ADR_CFG_VALUE, 32'h0, 4'h0);
      end
   endtask

   task automatic compare_values(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
      n_checks++;
      if (expected !== actual) begin
         n_err++;
         $display("ERR %s %s: expected %h, actual %h", name, what, expected, actual);
      end
   endtask

   task automatic apply_step(input step_t s);
      int waited;
      adr            = s.adr;
      cs             = (s.op != OP_ACT);
      we             = (s.op == OP_WRITE);
      sel            = s.sel;
      d              = s.data;
      drive_activity = s.act;
      @(negedge clk);
      waited = 1;
      // two cycles of the read already went by in the write and busy steps.
      while (s.op == OP_WAIT && q[31] && waited < `CFG_READ_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (s.op == OP_WAIT && q[31]) begin
         n_err++;
         $display("%s: configuration read still busy after %0d cycles", s.name, waited + 2);
      end
      compare_values(s.name, "q", s.exp_q, q);
      compare_values(s.name, "sw_reset", 32'(s.exp_sw), 32'(sw_reset));
      compare_values(s.name, "led_red_green", 32'(s.exp_stat), 32'({led_red, led_green}));
      for (int i = 0; i < 4; i++)
         compare_values(s.name, $sformatf("led%0d_rgb", i + 1), 32'(s.exp_led[i]),
                        32'(led_rgb[i]));
   endtask

   initial begin
      int first;
      int err_mark;
      adr            = 4'h0;
      cs             = 1'b0;
      sel            = 4'h0;
      we             = 1'b0;
      d              = 32'h0;
      drive_activity = 3'd0;
      first          = 0;
      err_mark       = 0;
      build_table();
      table_done = 1'b1;
      wait (reset == 1'b0);
      foreach (steps[k]) begin
         if (k > 0 && steps[k].name != steps[k - 1].name) begin
            $display("test %s: %0d steps, %0d errors", steps[k - 1].name, k - first,
                     n_err - err_mark);
            first    = k;
            err_mark = n_err;
         end
         apply_step(steps[k]);
      end
      $display("test %s: %0d steps, %0d errors", steps[steps.size() - 1].name,
               steps.size() - first, n_err - err_mark);
      $display("checks %0d, errors %0d", n_checks, n_err);
      if (n_err == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // the watchdog allows 20 cycles per table step on top of reset.
   initial begin
      wait (table_done);
      repeat (steps.size() * 20 + 10) @(posedge clk);
      $display("timeout: the table did not finish in %0d cycles", steps.size() * 20 + 10);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/misc_pkg.sv
hdl/mmio_bus_if.sv
hdl/icap_reader.sv
hdl/misc_regs.sv
hdl/misc_top.sv
bench/clock_gen.sv
bench/misc_tb.sv

/* Makefile */
SIM      = verilator
TOP      = misc_tb
RTL_TOP  = misc_top
FILELIST = all.f
FLAGS    = --binary --timing --assert
LINT     = --lint-only --timing -Wall
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
